/* source/soc_pkg.sv */
`default_nettype none

package soc_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // ram geometry in 32-bit words
   localparam int MEM_WORDS = 2048;
   localparam int MEM_AW    = $clog2(MEM_WORDS);

   // address bits 31:30 select the target
   localparam logic [1:0] REGION_MEM   = 2'd0;
   localparam logic [1:0] REGION_GPIO  = 2'd1;
   localparam logic [1:0] REGION_TIMER = 2'd2;

   // data-side request also used on the shared memory port
   typedef struct packed {
      logic [ADDR_W-1:0]   adr;
      logic [DATA_W-1:0]   dat;
      logic [DATA_W/8-1:0] sel; // byte lanes
      logic                we;
      logic                cyc;
   } wb_req_t;

   // read-only instruction fetch request
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic              cyc;
   } wb_ibus_req_t;

   // response from any slave
   typedef struct packed {
      logic [DATA_W-1:0] rdt;
      logic              ack;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* source/soc_bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_bus_arbiter (
   input  wire                   i_wb_clk,
   input  wire                   i_rst,
   input  soc_pkg::wb_ibus_req_t i_ibus,
   output soc_pkg::wb_rsp_t      o_ibus,
   input  soc_pkg::wb_req_t      i_dbus,
   output soc_pkg::wb_rsp_t      o_dbus,
   output soc_pkg::wb_req_t      o_mem,
   input  soc_pkg::wb_rsp_t      i_mem
);

   logic fetch; // fetch owns the port

   assign fetch = i_ibus.cyc;

   always_comb begin
      o_mem.adr = fetch ? i_ibus.adr : i_dbus.adr;
      o_mem.dat = i_dbus.dat;
      o_mem.sel = fetch ? '0 : i_dbus.sel; // no lanes on a fetch
      o_mem.we  = i_dbus.we & ~fetch;
      o_mem.cyc = i_ibus.cyc | i_dbus.cyc;
   end

   // shared read data with the ack steered to the bus in flight
   assign o_ibus.rdt = i_mem.rdt;
   assign o_ibus.ack = i_mem.ack & fetch;
   assign o_dbus.rdt = i_mem.rdt;
   assign o_dbus.ack = i_mem.ack & ~fetch;

   // the cpu issues one bus at a time
   a_one_master : assert property (
      @(posedge i_wb_clk) disable iff (i_rst)
      !(i_ibus.cyc && i_dbus.cyc)
   );

   // ram ack only ever answers a cycle that is still open
   a_ack_has_owner : assert property (
      @(posedge i_wb_clk) disable iff (i_rst)
      i_mem.ack |-> (i_ibus.cyc || i_dbus.cyc)
   );

endmodule

`default_nettype wire

/* source/soc_periph_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_periph_mux (
   input  wire                             i_wb_clk,
   input  wire                             i_rst,
   input  soc_pkg::wb_req_t                i_cpu,
   output soc_pkg::wb_rsp_t                o_cpu,
   output soc_pkg::wb_req_t                o_mem,
   input  soc_pkg::wb_rsp_t                i_mem,
   output soc_pkg::wb_req_t                o_periph,
   output logic                            o_periph_sel_timer,
   input  wire  [soc_pkg::DATA_W-1:0]      i_periph_rdt
);

   import soc_pkg::*;

   logic [1:0] region;
   logic       hit_mem;
   logic       hit_periph;
   logic       ack_q; // local ack for periph and unmapped

   assign region     = i_cpu.adr[31:30];
   assign hit_mem    = (region == REGION_MEM);
   assign hit_periph = (region == REGION_GPIO) || (region == REGION_TIMER);

   always_comb begin
      o_mem     = i_cpu;
      o_mem.cyc = i_cpu.cyc & hit_mem;
   end

   // one strobe per access so the write lands on the ack edge
   always_comb begin
      o_periph     = i_cpu;
      o_periph.cyc = i_cpu.cyc & hit_periph & ~ack_q;
   end

   assign o_periph_sel_timer = (region == REGION_TIMER);

   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_cpu.cyc & ~hit_mem & ~ack_q;
      end
   end

   always_comb begin
      case (region)
         REGION_MEM:   o_cpu.rdt = i_mem.rdt;
         REGION_GPIO,
         REGION_TIMER: o_cpu.rdt = i_periph_rdt;
         default:      o_cpu.rdt = '0; // unmapped reads zero
      endcase
   end

   assign o_cpu.ack = i_mem.ack | ack_q;

   // holds for ram and local acks alike
   a_ack_pulse : assert property (
      @(posedge i_wb_clk) disable iff (i_rst)
      o_cpu.ack |=> !o_cpu.ack
   );

   // every data cycle ends in an ack one cycle later
   a_ack_latency : assert property (
      @(posedge i_wb_clk) disable iff (i_rst)
      (i_cpu.cyc && !o_cpu.ack && !$past(i_cpu.cyc)) |=> o_cpu.ack
   );

endmodule

`default_nettype wire

/* source/soc_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_ram (
   input  wire              i_wb_clk,
   input  wire              i_rst,
   input  soc_pkg::wb_req_t i_req,
   output soc_pkg::wb_rsp_t o_rsp
);

   import soc_pkg::*;

   localparam int LANES = DATA_W / 8;

   logic [DATA_W-1:0] mem [MEM_WORDS];
   logic [MEM_AW-1:0] idx;
   logic [DATA_W-1:0] rdt_q;
   logic              ack_q;
   logic              access; // first cycle of a request

   assign idx    = i_req.adr[MEM_AW+1:2];
   assign access = i_req.cyc & ~ack_q;

   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // byte lane writes
   always_ff @(posedge i_wb_clk) begin
      if (access && i_req.we) begin
         for (int i = 0; i < LANES; i++) begin
            if (i_req.sel[i]) begin
               mem[idx][8*i +: 8] <= i_req.dat[8*i +: 8];
            end
         end
      end
   end

   // read data valid with ack
   always_ff @(posedge i_wb_clk) begin
      if (access) begin
         rdt_q <= mem[idx];
      end
   end

   assign o_rsp.rdt = rdt_q;
   assign o_rsp.ack = ack_q;

endmodule

`default_nettype wire

/* source/soc_periph_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_periph_regs (
   input  wire                        i_wb_clk,
   input  wire                        i_rst,
   input  soc_pkg::wb_req_t           i_req,
   input  wire                        i_sel_timer,
   output logic [soc_pkg::DATA_W-1:0] o_rdt,
   output logic                       o_gpio,
   output logic                       o_timer_irq
);

   import soc_pkg::*;

   logic [DATA_W-1:0] mtime;
   logic [DATA_W-1:0] mtimecmp;
   logic [DATA_W:0]   diff; // one extra bit so the sign is a true borrow
   logic              gpio_q;
   logic              irq_q;
   logic              wr_gpio;
   logic              wr_timer;

   assign wr_gpio  = i_req.cyc & i_req.we & ~i_sel_timer;
   assign wr_timer = i_req.cyc & i_req.we & i_sel_timer;

   // gpio output bit
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         gpio_q <= 1'b0;
      end else if (wr_gpio) begin
         gpio_q <= i_req.dat[0];
      end
   end

   // free running
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 1'b1;
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         mtimecmp <= '1; // irq parked low
      end else if (wr_timer) begin
         mtimecmp <= i_req.dat;
      end
   end

   assign diff = {1'b0, mtime} - {1'b0, mtimecmp};

   // level irq one cycle behind its inputs
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         irq_q <= 1'b0;
      end else begin
         irq_q <= ($signed(diff) >= 0);
      end
   end

   // read data qualified by ack in the mux
   always_comb begin
      if (i_sel_timer) begin
         o_rdt = mtime;
      end else begin
         o_rdt = {{(DATA_W-1){1'b0}}, gpio_q};
      end
   end

   assign o_gpio      = gpio_q;
   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

/* source/soc_fabric_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_top (
   input  wire                   i_wb_clk,
   input  wire                   i_rst,
   input  soc_pkg::wb_ibus_req_t i_ibus,
   output soc_pkg::wb_rsp_t      o_ibus,
   input  soc_pkg::wb_req_t      i_dbus,
   output soc_pkg::wb_rsp_t      o_dbus,
   output logic                  o_gpio,
   output logic                  o_timer_irq
);

   import soc_pkg::*;

   // data side toward the arbiter
   wb_req_t dmem_req;
   wb_rsp_t dmem_rsp;

   // shared memory port
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;

   // peripheral side
   wb_req_t           periph_req;
   logic              periph_sel_timer;
   logic [DATA_W-1:0] periph_rdt;

   soc_periph_mux soc_periph_mux_inst (
      .i_wb_clk           (i_wb_clk),
      .i_rst              (i_rst),
      .i_cpu              (i_dbus),
      .o_cpu              (o_dbus),
      .o_mem              (dmem_req),
      .i_mem              (dmem_rsp),
      .o_periph           (periph_req),
      .o_periph_sel_timer (periph_sel_timer),
      .i_periph_rdt       (periph_rdt)
   );

   soc_bus_arbiter soc_bus_arbiter_inst (
      .i_wb_clk (i_wb_clk),
      .i_rst    (i_rst),
      .i_ibus   (i_ibus),
      .o_ibus   (o_ibus),
      .i_dbus   (dmem_req),
      .o_dbus   (dmem_rsp),
      .o_mem    (mem_req),
      .i_mem    (mem_rsp)
   );

   soc_ram soc_ram_inst (
      .i_wb_clk (i_wb_clk),
      .i_rst    (i_rst),
      .i_req    (mem_req),
      .o_rsp    (mem_rsp)
   );

   soc_periph_regs soc_periph_regs_inst (
      .i_wb_clk    (i_wb_clk),
      .i_rst       (i_rst),
      .i_req       (periph_req),
      .i_sel_timer (periph_sel_timer),
      .o_rdt       (periph_rdt),
      .o_gpio      (o_gpio),
      .o_timer_irq (o_timer_irq)
   );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #20 o_clk = ~o_clk; // 40 ns period
   end

   initial begin
      o_rst = 1'b1;
      repeat (8) @(posedge o_clk);
      @(negedge o_clk); // release away from the active edge
      o_rst = 1'b0;
   end

endmodule

`default_nettype wire

/* tests/tb_soc_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_fabric;

   import soc_pkg::*;

   logic         clk;
   logic         rst;
   wb_ibus_req_t ibus;
   wb_rsp_t      ibus_rsp;
   wb_req_t      dbus;
   wb_rsp_t      dbus_rsp;
   logic         gpio;
   logic         timer_irq;

   logic [31:0]     rng;
   logic [31:0]     shadow [MEM_WORDS]; // model of ram contents
   bit              written [MEM_WORDS];

   tb_clock_gen tb_clock_gen_inst (
      .o_clk (clk),
      .o_rst (rst)
   );

   soc_fabric_top soc_fabric_top_inst (
      .i_wb_clk    (clk),
      .i_rst       (rst),
      .i_ibus      (ibus),
      .o_ibus      (ibus_rsp),
      .i_dbus      (dbus),
      .o_dbus      (dbus_rsp),
      .o_gpio      (gpio),
      .o_timer_irq (timer_irq)
   );

   task automatic stop_with_failure(input string reason);
      $display("Checks failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
         stop_with_failure("value mismatch");
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // master drops cyc one edge after the slave has seen its ack sampled
   task automatic dbus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdt);
      int cycles;
      @(negedge clk);
      dbus.adr = adr;
      dbus.dat = dat;
      dbus.sel = sel;
      dbus.we  = we;
      dbus.cyc = 1'b1;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!dbus_rsp.ack && cycles < 20);
      if (!dbus_rsp.ack) begin
         stop_with_failure("data bus got no ack within 20 cycles");
      end else begin
         rdt = dbus_rsp.rdt;
         @(negedge clk);
         dbus.cyc = 1'b0;
         dbus.we  = 1'b0;
      end
   endtask

   task automatic ibus_fetch(input logic [31:0] adr, output logic [31:0] rdt);
      int cycles;
      @(negedge clk);
      ibus.adr = adr;
      ibus.cyc = 1'b1;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!ibus_rsp.ack && cycles < 20);
      if (!ibus_rsp.ack) begin
         stop_with_failure("instruction bus got no ack within 20 cycles");
      end else begin
         rdt = ibus_rsp.rdt;
         @(negedge clk);
         ibus.cyc = 1'b0;
      end
   endtask

   task automatic wait_irq_level(input logic level);
      int cycles;
      cycles = 0;
      while (timer_irq !== level && cycles < 3) begin
         @(negedge clk);
         cycles++;
      end
      check_value("o_timer_irq", {31'd0, level}, {31'd0, timer_irq});
   endtask

   task automatic apply_pattern_file();
      int          fd;
      int          n;
      int          lines;
      string       line;
      logic [7:0]  op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [31:0] expv;
      logic [31:0] rd;
      fd = $fopen("tests/soc_patterns.txt", "r");
      if (fd == 0) stop_with_failure("cannot open tests/soc_patterns.txt");
      lines = 0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#") begin
            n = $sscanf(line, "%c %h %h %h %h", op, adr, dat, sel, expv);
            if (n == 5) begin
               lines++;
               case (op)
                  "W": dbus_access(1'b1, adr, dat, sel, rd);
                  "R": begin
                     dbus_access(1'b0, adr, 32'd0, sel, rd);
                     check_value("o_dbus.rdt", expv, rd);
                  end
                  "F": begin
                     ibus_fetch(adr, rd);
                     check_value("o_ibus.rdt", expv, rd);
                  end
                  "Q": begin
                     @(negedge clk);
                     check_value("o_timer_irq", expv, {31'd0, timer_irq});
                  end
                  default: stop_with_failure("unknown operation letter in pattern file");
               endcase
            end
         end
      end
      $fclose(fd);
      if (lines == 0) stop_with_failure("pattern file holds no operations");
   endtask

   task automatic random_ram_sweep();
      logic [31:0]       r;
      logic [31:0]       d;
      logic [31:0]       rd;
      logic [3:0]        sel;
      logic [MEM_AW-1:0] idx;
      logic [31:0]       adr;
      for (int i = 0; i < 300; i++) begin
         rng = xorshift(rng);
         r   = rng;
         idx = {r[20:18], 5'd0, r[2:0]}; // 64 slots spread over the array
         adr = {{(ADDR_W-MEM_AW-2){1'b0}}, idx, 2'b00};
         if (r[17:16] == 2'd0 || !written[idx]) begin
            rng = xorshift(rng);
            d   = rng;
            sel = written[idx] ? r[23:20] : 4'hf; // fresh words get all lanes
            dbus_access(1'b1, adr, d, sel, rd);
            for (int l = 0; l < 4; l++) begin
               if (sel[l]) shadow[idx][8*l +: 8] = d[8*l +: 8];
            end
            written[idx] = 1'b1;
         end else if (r[17:16] == 2'd1) begin
            ibus_fetch(adr, rd);
            check_value("o_ibus.rdt", shadow[idx], rd);
         end else begin
            dbus_access(1'b0, adr, 32'd0, 4'hf, rd);
            check_value("o_dbus.rdt", shadow[idx], rd);
         end
      end
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] t0;
      logic [31:0] t1;
      int          n;
      ibus = '0;
      dbus = '0;
      rng  = 32'd89223;

      n = 0;
      while (rst !== 1'b0 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (rst !== 1'b0) stop_with_failure("reset was never released");

      check_value("o_gpio", 32'd0, {31'd0, gpio});
      check_value("o_timer_irq", 32'd0, {31'd0, timer_irq});
      repeat (4) begin
         @(negedge clk);
         check_value("o_ibus.ack", 32'd0, {31'd0, ibus_rsp.ack});
         check_value("o_dbus.ack", 32'd0, {31'd0, dbus_rsp.ack});
      end

      apply_pattern_file();
      random_ram_sweep();

      // gpio bit follows the write once acked
      dbus_access(1'b1, {REGION_GPIO, 30'd0}, 32'd1, 4'hf, rd);
      check_value("o_gpio", 32'd1, {31'd0, gpio});
      dbus_access(1'b0, {REGION_GPIO, 30'd0}, 32'd0, 4'hf, rd);
      check_value("o_dbus.rdt", 32'd1, rd);
      dbus_access(1'b1, {REGION_GPIO, 30'd0}, 32'd0, 4'hf, rd);
      check_value("o_gpio", 32'd0, {31'd0, gpio});
      dbus_access(1'b0, {REGION_GPIO, 30'd0}, 32'd0, 4'hf, rd);
      check_value("o_dbus.rdt", 32'd0, rd);

      // mtime runs and then becomes the compare value
      dbus_access(1'b0, {REGION_TIMER, 30'd0}, 32'd0, 4'hf, t0);
      dbus_access(1'b0, {REGION_TIMER, 30'd0}, 32'd0, 4'hf, t1);
      check_value("mtime nonzero", 32'd1, {31'd0, t0 != 32'd0});
      check_value("mtime increasing", 32'd1, {31'd0, t1 > t0});
      dbus_access(1'b1, {REGION_TIMER, 30'd0}, t1, 4'hf, rd);
      wait_irq_level(1'b1);
      dbus_access(1'b1, {REGION_TIMER, 30'd0}, 32'hffff_ffff, 4'hf, rd);
      wait_irq_level(1'b0);

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/soc_patterns.txt */
# op: W data write, R data read, F fetch, Q irq level check
# columns: op address data sel expected, all hex
Q 00000000 00000000 0 00000000
W 00000100 11223344 f 00000000
R 00000100 00000000 f 11223344
W 00000100 aabbccdd 1 00000000
R 00000100 00000000 f 112233dd
W 00000100 55667788 6 00000000
R 00000100 00000000 f 116677dd
W 00000100 99000000 8 00000000
R 00000100 00000000 f 996677dd
F 00000100 00000000 0 996677dd
W 00000104 0badf00d f 00000000
W 00000104 12345678 c 00000000
R 00000104 00000000 f 1234f00d
F 00000104 00000000 0 1234f00d
W 00001ffc deadbeef f 00000000
W 00001ffc 00000042 2 00000000
R 00001ffc 00000000 f dead00ef
F 00001ffc 00000000 0 dead00ef
F 00000100 00000000 0 996677dd
W 40000000 00000001 f 00000000
R 40000000 00000000 f 00000001
W 40000000 00000000 f 00000000
R 40000000 00000000 f 00000000
W c0000010 ffffffff f 00000000
R c0000010 00000000 f 00000000
R c0000000 00000000 f 00000000
R 00000104 00000000 f 1234f00d
Q 00000000 00000000 0 00000000

/* filelist.f */
source/soc_pkg.sv
source/soc_bus_arbiter.sv
source/soc_periph_mux.sv
source/soc_ram.sv
source/soc_periph_regs.sv
source/soc_fabric_top.sv
tests/tb_clock_gen.sv
tests/tb_soc_fabric.sv

/* Makefile */
# Verilator build for the bus fabric testbench
# run from the project root so the pattern file path resolves

TOP = tb_soc_fabric

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard source/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
